// ==== rtl/link_pkg.sv ====
package link_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////////////////////

	// 32-bit words in each link block
	localparam int WORD_PER_LINK = 4;

	// Word indices inside a link block
	localparam int REG_CTRL   = 0;
	localparam int REG_SLIP   = 1;
	localparam int REG_ERRS   = 2;
	localparam int REG_RXWORD = 3;

	// CTRL bits
	localparam int CTRL_BYPASS   = 0;
	localparam int CTRL_TRISTATE = 1;
	localparam int CTRL_CHECK    = 2;
	// Self-clearing, reads back as 0
	localparam int CTRL_CLEAR    = 3;

	// Global word, block NLINKS word 0
	localparam int GLB_CLEAR  = 0;
	localparam int GLB_ENABLE = 1;

	////////////////////////////////////////////////////////////////////////////
	// Alignment
	////////////////////////////////////////////////////////////////////////////

	// Pattern sent by the far end during training
	localparam logic [7:0] TRAIN_WORD = 8'hA6;

	// Saturating error count width
	localparam int ERR_WIDTH = 16;

	// Bit-slip offset, 0 to 7
	localparam int SLIP_WIDTH = 3;

endpackage

// ==== rtl/link_config_regs.sv ====
`timescale 1ns/1ps

module link_config_regs import link_pkg::*; #(
	parameter int NLINKS = 4
) (
	input  logic                                in_clk160,
	input  logic                                reset,
	input  logic [(NLINKS+1)*WORD_PER_LINK-1:0] bus_wrce,
	input  logic [31:0]                         bus_data,
	output logic [NLINKS-1:0]                   lane_bypass,
	output logic [NLINKS-1:0]                   lane_tristate,
	output logic [NLINKS-1:0]                   lane_check,
	output logic [NLINKS*SLIP_WIDTH-1:0]        lane_slip,
	output logic [NLINKS-1:0]                   lane_clear,
	output logic                                link_enable,
	output logic                                bus_wrack
);

	// Bit w of bus_wrce selects word w, lane i owns words i*WORD_PER_LINK and up
	localparam int GLB_WORD = NLINKS * WORD_PER_LINK;

	// Write strobes decoded per lane
	logic [NLINKS-1:0] ctrl_wr;
	logic [NLINKS-1:0] slip_wr;
	logic              glb_wr;
	logic              glb_clear_wr;

	always_comb begin
		for (int i = 0; i < NLINKS; i++) begin
			ctrl_wr[i] = bus_wrce[i*WORD_PER_LINK + REG_CTRL];
			slip_wr[i] = bus_wrce[i*WORD_PER_LINK + REG_SLIP];
		end
	end

	assign glb_wr       = bus_wrce[GLB_WORD];
	assign glb_clear_wr = glb_wr & bus_data[GLB_CLEAR];

	////////////////////////////////////////////////////////////////////////////
	// Per-lane control levels
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge in_clk160) begin
		if (reset) begin
			lane_bypass   <= '0;
			lane_tristate <= '0;
			lane_check    <= '0;
		end else begin
			for (int i = 0; i < NLINKS; i++) begin
				if (ctrl_wr[i]) begin
					lane_bypass[i]   <= bus_data[CTRL_BYPASS];
					lane_tristate[i] <= bus_data[CTRL_TRISTATE];
					lane_check[i]    <= bus_data[CTRL_CHECK];
				end
			end
		end
	end

	always_ff @(posedge in_clk160) begin
		if (reset) begin
			lane_slip <= '0;
		end else begin
			for (int i = 0; i < NLINKS; i++) begin
				if (slip_wr[i]) begin
					lane_slip[i*SLIP_WIDTH +: SLIP_WIDTH] <= bus_data[SLIP_WIDTH-1:0];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Clear pulses
	////////////////////////////////////////////////////////////////////////////

	// Lane clear and global clear merge into a single one-cycle pulse per lane
	always_ff @(posedge in_clk160) begin
		if (reset) begin
			lane_clear <= '0;
		end else begin
			for (int i = 0; i < NLINKS; i++) begin
				lane_clear[i] <= (ctrl_wr[i] & bus_data[CTRL_CLEAR]) | glb_clear_wr;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Global enable and write acknowledge
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge in_clk160) begin
		if (reset) begin
			link_enable <= 1'b0;
		end else if (glb_wr) begin
			link_enable <= bus_data[GLB_ENABLE];
		end
	end

	// Ack one cycle after any write strobe, ERRS and RXWORD writes included
	always_ff @(posedge in_clk160) begin
		if (reset) begin
			bus_wrack <= 1'b0;
		end else begin
			bus_wrack <= |bus_wrce;
		end
	end

endmodule

// ==== rtl/link_lane.sv ====
`timescale 1ns/1ps

module link_lane import link_pkg::*; (
	input  logic                  in_clk160,
	input  logic                  reset,
	input  logic [7:0]            tx_data,
	input  logic                  tx_valid,
	input  logic                  bypass,
	input  logic                  tristate,
	input  logic                  check,
	input  logic [SLIP_WIDTH-1:0] slip,
	input  logic                  clear,
	input  logic                  enable,
	output logic [7:0]            rx_word,
	output logic [ERR_WIDTH-1:0]  errors
);

	logic [7:0]  tx_reg;
	logic        tx_drive;
	logic [7:0]  line_p;
	logic [7:0]  line_n;
	logic [7:0]  line_rx;
	logic [7:0]  rx_cur;
	logic [7:0]  rx_prev;
	logic [15:0] window;
	logic [7:0]  slip_out;
	logic [7:0]  byp_reg;

	////////////////////////////////////////////////////////////////////////////
	// Transmit side
	////////////////////////////////////////////////////////////////////////////

	// Stage 1 holds the byte and its drive condition
	always_ff @(posedge in_clk160) begin
		tx_reg <= tx_data;
	end

	always_ff @(posedge in_clk160) begin
		if (reset) begin
			tx_drive <= 1'b0;
		end else begin
			tx_drive <= tx_valid & ~tristate;
		end
	end

	// Differential pair with both legs low when released
	assign line_p = tx_drive ? tx_reg : 8'h00;
	assign line_n = tx_drive ? ~tx_reg : 8'h00;

	// Receiver sees a one only on a true P-high N-low pair
	assign line_rx = line_p & ~line_n;

	////////////////////////////////////////////////////////////////////////////
	// Receive side and bit-slip
	////////////////////////////////////////////////////////////////////////////

	// Stage 2 captures the byte and keeps the one before it
	always_ff @(posedge in_clk160) begin
		if (reset || !enable) begin
			rx_cur  <= 8'h00;
			rx_prev <= 8'h00;
		end else begin
			rx_cur  <= line_rx;
			rx_prev <= rx_cur;
		end
	end

	// Older byte on top so offset k picks bits k+7 down to k
	assign window = {rx_prev, rx_cur};

	// Stage 3
	always_ff @(posedge in_clk160) begin
		if (reset || !enable) begin
			slip_out <= 8'h00;
		end else begin
			slip_out <= window[{1'b0, slip} +: 8];
		end
	end

	// Bypass copy as the second stage after tx_reg
	always_ff @(posedge in_clk160) begin
		byp_reg <= tx_reg;
	end

	assign rx_word = bypass ? byp_reg : slip_out;

	////////////////////////////////////////////////////////////////////////////
	// Training word error count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge in_clk160) begin
		if (reset || !enable || clear) begin
			errors <= '0;
		end else if (check && slip_out != TRAIN_WORD && errors != '1) begin
			errors <= errors + 1'b1;
		end
	end

endmodule

// ==== rtl/link_readback.sv ====
`timescale 1ns/1ps

module link_readback import link_pkg::*; #(
	parameter int NLINKS = 4
) (
	input  logic                                in_clk160,
	input  logic                                reset,
	input  logic [(NLINKS+1)*WORD_PER_LINK-1:0] bus_rdce,
	input  logic [NLINKS-1:0]                   lane_bypass,
	input  logic [NLINKS-1:0]                   lane_tristate,
	input  logic [NLINKS-1:0]                   lane_check,
	input  logic [NLINKS*SLIP_WIDTH-1:0]        lane_slip,
	input  logic                                link_enable,
	input  logic [NLINKS*8-1:0]                 lane_rx_word,
	input  logic [NLINKS*ERR_WIDTH-1:0]         lane_errors,
	output logic [31:0]                         bus_rdata,
	output logic                                bus_rdack
);

	localparam int NWORDS = (NLINKS + 1) * WORD_PER_LINK;
	localparam int LANE_W = $clog2(NLINKS + 1);
	localparam int REG_W  = $clog2(WORD_PER_LINK);

	logic [LANE_W-1:0] sel_lane;
	logic [REG_W-1:0]  sel_reg;
	logic [31:0]       rd_word;

	// One-hot strobe to block and word index
	always_comb begin
		sel_lane = '0;
		sel_reg  = '0;
		for (int w = 0; w < NWORDS; w++) begin
			if (bus_rdce[w]) begin
				sel_lane = LANE_W'(w / WORD_PER_LINK);
				sel_reg  = REG_W'(w % WORD_PER_LINK);
			end
		end
	end

	// Clear bits are pulses and are left out of the read word
	always_comb begin
		rd_word = '0;
		if (sel_lane == LANE_W'(NLINKS)) begin
			if (sel_reg == REG_W'(REG_CTRL)) begin
				rd_word[GLB_ENABLE] = link_enable;
			end
		end else begin
			case (sel_reg)
				REG_W'(REG_CTRL): begin
					rd_word[CTRL_BYPASS]   = lane_bypass[int'(sel_lane)];
					rd_word[CTRL_TRISTATE] = lane_tristate[int'(sel_lane)];
					rd_word[CTRL_CHECK]    = lane_check[int'(sel_lane)];
				end
				REG_W'(REG_SLIP): begin
					rd_word[SLIP_WIDTH-1:0] =
						lane_slip[sel_lane*SLIP_WIDTH +: SLIP_WIDTH];
				end
				REG_W'(REG_ERRS): begin
					rd_word[ERR_WIDTH-1:0] =
						lane_errors[sel_lane*ERR_WIDTH +: ERR_WIDTH];
				end
				REG_W'(REG_RXWORD): begin
					rd_word[7:0] = lane_rx_word[sel_lane*8 +: 8];
				end
				default:            rd_word = '0;
			endcase
		end
	end

	// Data only valid alongside the ack and zero otherwise
	always_ff @(posedge in_clk160) begin
		if (reset) begin
			bus_rdata <= '0;
			bus_rdack <= 1'b0;
		end else begin
			bus_rdata <= (|bus_rdce) ? rd_word : 32'h0;
			bus_rdack <= |bus_rdce;
		end
	end

endmodule

// ==== rtl/io_link_array.sv ====
`timescale 1ns/1ps

module io_link_array import link_pkg::*; #(
	parameter int NLINKS = 4
) (
	input  logic                                in_clk160,
	input  logic                                reset,
	input  logic [NLINKS*8-1:0]                 in_tdata,
	input  logic [NLINKS-1:0]                   in_tvalid,
	input  logic [(NLINKS+1)*WORD_PER_LINK-1:0] bus_wrce,
	input  logic [(NLINKS+1)*WORD_PER_LINK-1:0] bus_rdce,
	input  logic [31:0]                         bus_data,
	output logic [NLINKS*8-1:0]                 out_tdata,
	output logic [31:0]                         bus_rdata,
	output logic                                bus_wrack,
	output logic                                bus_rdack
);

	// Control from the decoder, lane i in slice i
	logic [NLINKS-1:0]            lane_bypass;
	logic [NLINKS-1:0]            lane_tristate;
	logic [NLINKS-1:0]            lane_check;
	logic [NLINKS*SLIP_WIDTH-1:0] lane_slip;
	logic [NLINKS-1:0]            lane_clear;
	logic                         link_enable;

	// Status from the lanes
	logic [NLINKS*8-1:0]          lane_rx_word;
	logic [NLINKS*ERR_WIDTH-1:0]  lane_errors;

	////////////////////////////////////////////////////////////////////////////
	// Register write side
	////////////////////////////////////////////////////////////////////////////

	link_config_regs #(
		.NLINKS (NLINKS)
	) i_link_config_regs (
		.in_clk160     (in_clk160),
		.reset         (reset),
		.bus_wrce      (bus_wrce),
		.bus_data      (bus_data),
		.lane_bypass   (lane_bypass),
		.lane_tristate (lane_tristate),
		.lane_check    (lane_check),
		.lane_slip     (lane_slip),
		.lane_clear    (lane_clear),
		.link_enable   (link_enable),
		.bus_wrack     (bus_wrack)
	);

	////////////////////////////////////////////////////////////////////////////
	// Links
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NLINKS; i++) begin : g_lane
		link_lane i_link_lane (
			.in_clk160 (in_clk160),
			.reset     (reset),
			.tx_data   (in_tdata[i*8 +: 8]),
			.tx_valid  (in_tvalid[i]),
			.bypass    (lane_bypass[i]),
			.tristate  (lane_tristate[i]),
			.check     (lane_check[i]),
			.slip      (lane_slip[i*SLIP_WIDTH +: SLIP_WIDTH]),
			.clear     (lane_clear[i]),
			.enable    (link_enable),
			.rx_word   (lane_rx_word[i*8 +: 8]),
			.errors    (lane_errors[i*ERR_WIDTH +: ERR_WIDTH])
		);
	end

	assign out_tdata = lane_rx_word;

	////////////////////////////////////////////////////////////////////////////
	// Register read side
	////////////////////////////////////////////////////////////////////////////

	link_readback #(
		.NLINKS (NLINKS)
	) i_link_readback (
		.in_clk160     (in_clk160),
		.reset         (reset),
		.bus_rdce      (bus_rdce),
		.lane_bypass   (lane_bypass),
		.lane_tristate (lane_tristate),
		.lane_check    (lane_check),
		.lane_slip     (lane_slip),
		.link_enable   (link_enable),
		.lane_rx_word  (lane_rx_word),
		.lane_errors   (lane_errors),
		.bus_rdata     (bus_rdata),
		.bus_rdack     (bus_rdack)
	);

endmodule

// ==== bench/io_link_array_tb.sv ====
`timescale 1ns/1ps

module io_link_array_tb import link_pkg::*; ();

	localparam int NL     = 4;
	localparam int NWORDS = (NL + 1) * WORD_PER_LINK;
	localparam int GLB    = NL;

	// Row kinds and data sources
	localparam int OP_NOP = 0;
	localparam int OP_WR  = 1;
	localparam int OP_RD  = 2;
	localparam int DM_RND = 0;
	localparam int DM_FIX = 1;

	// Bus op in the first cycle of a row, data for all count cycles
	typedef struct packed {
		int          op;
		int          lane;
		int          word;
		logic [31:0] wdata;
		int          dmode;
		int          dval;
		int          valid;
		logic [31:0] exp_val;
		int          use_model;
		int          count;
	} step_t;

	logic              in_clk160;
	logic              reset;
	logic [NL*8-1:0]   in_tdata;
	logic [NL-1:0]     in_tvalid;
	logic [NWORDS-1:0] bus_wrce;
	logic [NWORDS-1:0] bus_rdce;
	logic [31:0]       bus_data;
	logic [NL*8-1:0]   out_tdata;
	logic [31:0]       bus_rdata;
	logic              bus_wrack;
	logic              bus_rdack;

	step_t tbl[$];
	int    seed = 20749;
	int    err_count = 0;
	int    total_cycles = 0;
	int    cycles_run = 0;
	bit    table_ready = 0;

	// Reference model, lane i in entry i
	logic [7:0]           sent_q0    [NL];
	logic [7:0]           sent_q1    [NL];
	logic [7:0]           line_q     [NL];
	logic [7:0]           rx_new     [NL];
	logic [7:0]           rx_old     [NL];
	logic [7:0]           aligned    [NL];
	logic [ERR_WIDTH-1:0] err_model  [NL];
	logic [7:0]           exp_out    [NL];
	logic                 c_bypass   [NL];
	logic                 c_tristate [NL];
	logic                 c_check    [NL];
	logic                 c_clear    [NL];
	logic [2:0]           c_slip     [NL];
	logic                 c_enable;

	// Bus responses due in the next cycle
	bit          wr_pending;
	bit          rd_pending;
	logic [31:0] rd_exp;

	io_link_array #(
		.NLINKS (NL)
	) i_io_link_array (
		.in_clk160 (in_clk160),
		.reset     (reset),
		.in_tdata  (in_tdata),
		.in_tvalid (in_tvalid),
		.bus_wrce  (bus_wrce),
		.bus_rdce  (bus_rdce),
		.bus_data  (bus_data),
		.out_tdata (out_tdata),
		.bus_rdata (bus_rdata),
		.bus_wrack (bus_wrack),
		.bus_rdack (bus_rdack)
	);

	initial begin
		in_clk160 = 1'b0;
		forever #20 in_clk160 = ~in_clk160;
	end

	task automatic add_row(input int op, input int lane, input int word,
		input logic [31:0] wdata, input int dmode, input int dval, input int valid,
		input logic [31:0] exp_val, input int use_model, input int count);
		step_t row;
		row = '{op, lane, word, wdata, dmode, dval, valid, exp_val, use_model, count};
		tbl.push_back(row);
		total_cycles += count;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and expected values
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		// Reset values
		add_row(OP_RD,  0,   REG_CTRL,   32'h0, DM_RND, 0,    'h0, 32'h0, 0, 1);
		add_row(OP_RD,  GLB, REG_CTRL,   32'h0, DM_RND, 0,    'h0, 32'h0, 0, 1);
		add_row(OP_RD,  2,   REG_SLIP,   32'h0, DM_RND, 0,    'h0, 32'h0, 0, 1);
		// Loopback, offset 0, some lanes idle
		add_row(OP_WR,  GLB, REG_CTRL,   32'h2, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_RD,  GLB, REG_CTRL,   32'h0, DM_RND, 0,    'hF, 32'h2, 0, 10);
		add_row(OP_NOP, 0,   0,          32'h0, DM_RND, 0,    'h5, 32'h0, 0, 6);
		add_row(OP_RD,  3,   REG_RXWORD, 32'h0, DM_RND, 0,    'hF, 32'h0, 1, 3);
		// Bit-slip, offsets 1 to 7
		add_row(OP_WR,  0,   REG_SLIP,   32'h1, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  1,   REG_SLIP,   32'h3, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  2,   REG_SLIP,   32'h5, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  3,   REG_SLIP,   32'h7, DM_RND, 0,    'hF, 32'h0, 0, 8);
		add_row(OP_RD,  1,   REG_SLIP,   32'h0, DM_RND, 0,    'hF, 32'h3, 0, 1);
		add_row(OP_RD,  3,   REG_SLIP,   32'h0, DM_RND, 0,    'hF, 32'h7, 0, 1);
		add_row(OP_WR,  0,   REG_SLIP,   32'h2, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  1,   REG_SLIP,   32'h4, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  2,   REG_SLIP,   32'h6, DM_RND, 0,    'hF, 32'h0, 0, 8);
		add_row(OP_RD,  2,   REG_RXWORD, 32'h0, DM_RND, 0,    'hF, 32'h0, 1, 1);
		add_row(OP_WR,  0,   REG_SLIP,   32'h0, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  1,   REG_SLIP,   32'h0, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  2,   REG_SLIP,   32'h0, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  3,   REG_SLIP,   32'h0, DM_RND, 0,    'hF, 32'h0, 0, 4);
		// Bypass, with tristate and then with the links disabled
		add_row(OP_WR,  0,   REG_CTRL,   32'h1, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  1,   REG_CTRL,   32'h3, DM_RND, 0,    'hF, 32'h0, 0, 6);
		add_row(OP_RD,  1,   REG_CTRL,   32'h0, DM_RND, 0,    'hF, 32'h3, 0, 1);
		add_row(OP_WR,  GLB, REG_CTRL,   32'h0, DM_RND, 0,    'hF, 32'h0, 0, 6);
		add_row(OP_RD,  0,   REG_RXWORD, 32'h0, DM_RND, 0,    'hF, 32'h0, 1, 1);
		add_row(OP_WR,  GLB, REG_CTRL,   32'h2, DM_RND, 0,    'hF, 32'h0, 0, 1);
		// Tristate without bypass
		add_row(OP_WR,  0,   REG_CTRL,   32'h0, DM_RND, 0,    'hF, 32'h0, 0, 1);
		add_row(OP_WR,  1,   REG_CTRL,   32'h2, DM_RND, 0,    'hF, 32'h0, 0, 6);
		add_row(OP_RD,  1,   REG_CTRL,   32'h0, DM_RND, 0,    'hF, 32'h2, 0, 1);
		add_row(OP_RD,  1,   REG_RXWORD, 32'h0, DM_RND, 0,    'hF, 32'h0, 1, 1);
		add_row(OP_WR,  1,   REG_CTRL,   32'h0, DM_RND, 0,    'hF, 32'h0, 0, 4);
		// Training stream with bad bytes mixed in
		add_row(OP_WR,  0,   REG_CTRL,   32'h4, DM_FIX, 'hA6, 'hF, 32'h0, 0, 1);
		add_row(OP_WR,  1,   REG_CTRL,   32'h4, DM_FIX, 'hA6, 'hF, 32'h0, 0, 1);
		add_row(OP_WR,  2,   REG_CTRL,   32'h4, DM_FIX, 'hA6, 'hF, 32'h0, 0, 1);
		add_row(OP_WR,  3,   REG_CTRL,   32'h4, DM_FIX, 'hA6, 'hF, 32'h0, 0, 6);
		add_row(OP_NOP, 0,   0,          32'h0, DM_FIX, 'h5A, 'hF, 32'h0, 0, 2);
		add_row(OP_NOP, 0,   0,          32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 0, 5);
		add_row(OP_NOP, 0,   0,          32'h0, DM_FIX, 'hA6, 'h6, 32'h0, 0, 1);
		add_row(OP_NOP, 0,   0,          32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 0, 5);
		add_row(OP_RD,  0,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		add_row(OP_RD,  1,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		add_row(OP_RD,  2,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		add_row(OP_RD,  3,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		// Lane 1 clear, then global clear
		add_row(OP_WR,  1,   REG_CTRL,   32'hC, DM_FIX, 'hA6, 'hF, 32'h0, 0, 4);
		add_row(OP_RD,  1,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		add_row(OP_RD,  0,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		add_row(OP_RD,  1,   REG_CTRL,   32'h0, DM_FIX, 'hA6, 'hF, 32'h4, 0, 1);
		add_row(OP_WR,  GLB, REG_CTRL,   32'h3, DM_FIX, 'hA6, 'hF, 32'h0, 0, 4);
		add_row(OP_RD,  0,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		add_row(OP_RD,  2,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 1);
		add_row(OP_RD,  3,   REG_ERRS,   32'h0, DM_FIX, 'hA6, 'hF, 32'h0, 1, 3);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_model();
		for (int i = 0; i < NL; i++) begin
			sent_q0[i]    = 8'h00;
			sent_q1[i]    = 8'h00;
			line_q[i]     = 8'h00;
			rx_new[i]     = 8'h00;
			rx_old[i]     = 8'h00;
			aligned[i]    = 8'h00;
			err_model[i]  = '0;
			exp_out[i]    = 8'h00;
			c_bypass[i]   = 1'b0;
			c_tristate[i] = 1'b0;
			c_check[i]    = 1'b0;
			c_clear[i]    = 1'b0;
			c_slip[i]     = 3'd0;
		end
		c_enable = 1'b0;
	endtask

	// One clock edge, fed with the inputs of the cycle that just ended
	task automatic advance_model();
		logic [15:0] win;
		for (int i = 0; i < NL; i++) begin
			if (c_clear[i] || !c_enable) begin
				err_model[i] = '0;
			end else if (c_check[i] && aligned[i] != TRAIN_WORD &&
					err_model[i] != {ERR_WIDTH{1'b1}}) begin
				err_model[i] = err_model[i] + 1'b1;
			end
			// Older received byte on top of the window
			win = {rx_old[i], rx_new[i]};
			aligned[i] = c_enable ? 8'(win >> c_slip[i]) : 8'h00;
			rx_old[i]  = c_enable ? rx_new[i] : 8'h00;
			rx_new[i]  = c_enable ? line_q[i] : 8'h00;
			// Released line reads as zeros
			line_q[i]  = (in_tvalid[i] && !c_tristate[i]) ? in_tdata[i*8 +: 8] : 8'h00;
			sent_q1[i] = sent_q0[i];
			sent_q0[i] = in_tdata[i*8 +: 8];
			c_clear[i] = 1'b0;
			if (bus_wrce[i*WORD_PER_LINK + REG_CTRL]) begin
				c_bypass[i]   = bus_data[CTRL_BYPASS];
				c_tristate[i] = bus_data[CTRL_TRISTATE];
				c_check[i]    = bus_data[CTRL_CHECK];
				c_clear[i]    = bus_data[CTRL_CLEAR];
			end
			if (bus_wrce[i*WORD_PER_LINK + REG_SLIP]) begin
				c_slip[i] = bus_data[2:0];
			end
		end
		if (bus_wrce[GLB*WORD_PER_LINK]) begin
			c_enable = bus_data[GLB_ENABLE];
			for (int i = 0; i < NL; i++) begin
				c_clear[i] = c_clear[i] | bus_data[GLB_CLEAR];
			end
		end
		for (int i = 0; i < NL; i++) begin
			exp_out[i] = c_bypass[i] ? sent_q1[i] : aligned[i];
		end
	endtask

	function automatic logic [31:0] model_read(input int lane, input int word);
		if (word == REG_ERRS) begin
			return 32'(err_model[lane]);
		end
		return 32'(exp_out[lane]);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_step(input step_t row, input bit first);
		int idx;
		idx = row.lane * WORD_PER_LINK + row.word;
		bus_wrce = '0;
		bus_rdce = '0;
		bus_data = '0;
		if (first && row.op == OP_WR) begin
			bus_wrce[idx] = 1'b1;
			bus_data      = row.wdata;
			wr_pending    = 1'b1;
		end
		if (first && row.op == OP_RD) begin
			bus_rdce[idx] = 1'b1;
			rd_pending    = 1'b1;
			rd_exp = (row.use_model != 0) ? model_read(row.lane, row.word) : row.exp_val;
		end
		for (int i = 0; i < NL; i++) begin
			in_tdata[i*8 +: 8] = (row.dmode == DM_RND) ? 8'($random(seed)) : 8'(row.dval);
		end
		in_tvalid = NL'(row.valid);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		assert (act_val === exp_val) else begin
			err_count++;
			$display("ERROR: time %0t %s expected %h actual %h", $time, name, exp_val, act_val);
		end
	endtask

	task automatic check_outputs();
		for (int i = 0; i < NL; i++) begin
			compare_value($sformatf("out_tdata[%0d]", i), 32'(exp_out[i]),
				32'(out_tdata[i*8 +: 8]));
		end
		compare_value("bus_wrack", 32'(wr_pending), 32'(bus_wrack));
		compare_value("bus_rdack", 32'(rd_pending), 32'(bus_rdack));
		compare_value("bus_rdata", rd_pending ? rd_exp : 32'h0, bus_rdata);
		wr_pending = 1'b0;
		rd_pending = 1'b0;
	endtask

	initial begin
		reset      = 1'b1;
		in_tdata   = '0;
		in_tvalid  = '0;
		bus_wrce   = '0;
		bus_rdce   = '0;
		bus_data   = '0;
		wr_pending = 1'b0;
		rd_pending = 1'b0;
		rd_exp     = '0;
		build_table();
		table_ready = 1'b1;
		reset_model();
		repeat (2) @(posedge in_clk160);
		#2;
		reset = 1'b0;
		check_outputs();
		for (int r = 0; r < tbl.size(); r++) begin
			for (int k = 0; k < tbl[r].count; k++) begin
				apply_step(tbl[r], k == 0);
				@(posedge in_clk160);
				#2;
				advance_model();
				check_outputs();
				cycles_run++;
			end
		end
		$display("Summary: %0d cycles run, %0d errors", cycles_run, err_count);
		if (err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Twice the table length plus room for reset
	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = total_cycles * 40 * 2 + 2000;
		#(limit_ns);
		$display("Watchdog expired after %0d ns, the test table did not finish", limit_ns);
		$display("Summary: %0d cycles run, %0d errors", cycles_run, err_count);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
rtl/link_pkg.sv
rtl/link_config_regs.sv
rtl/link_lane.sv
rtl/link_readback.sv
rtl/io_link_array.sv
bench/io_link_array_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the io_link_array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=io_link_array_sim

verilator --binary --timing --assert -f project.f --top-module io_link_array_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "Simulation log holds no pass line"
	exit 1
fi
exit 0
